// File: hdl/audio_fir.sv
// mono voice-band filter between an I2S ADC and DAC, both as slave
// only the left input is filtered; output goes to both DAC slots
`timescale 1ns/1ps
`include "audio_defs.svh"

module audio_fir import audio_pkg::*; (
  input  logic sys_clk,
  input  logic rst_n,
  input  logic bclk,
  input  logic lrck,
  input  logic sdin,
  input  logic bypass,
  output logic sdout
);

  frame_t                frame;
  logic                  frame_vld;
  tap_vec_t              taps;
  logic                  shift_vld;
  prod_t [`FIR_TAPS-1:0] prods;
  logic                  prod_vld;
  sample_t               out_sample;
  logic                  out_vld;

  i2s_rx u_rx (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .bclk      (bclk),
    .lrck      (lrck),
    .sdin      (sdin),
    .frame     (frame),
    .frame_vld (frame_vld)
  );

  fir_delay_line u_delay (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .frame_vld (frame_vld),
    .left      (frame.left),
    .taps      (taps),
    .shift_vld (shift_vld)
  );

  // tap 0 carries the strobe for all taps
  for (genvar i = 0; i < `FIR_TAPS; i++) begin : g_tap
    if (i == 0) begin : g_lead
      fir_tap #(.coef(FIR_COEF[i])) u_tap (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .in_vld   (shift_vld),
        .x        (taps[i]),
        .prod     (prods[i]),
        .prod_vld (prod_vld)
      );
    end else begin : g_rest
      fir_tap #(.coef(FIR_COEF[i])) u_tap (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .in_vld   (shift_vld),
        .x        (taps[i]),
        .prod     (prods[i]),
        .prod_vld ()
      );
    end
  end

  fir_sum u_sum (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .prod_vld   (prod_vld),
    .prods      (prods),
    .raw        (taps[0]),
    .bypass     (bypass),
    .out_sample (out_sample),
    .out_vld    (out_vld)
  );

  i2s_tx u_tx (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .bclk       (bclk),
    .lrck       (lrck),
    .out_vld    (out_vld),
    .out_sample (out_sample),
    .sdout      (sdout)
  );

endmodule

// File: hdl/audio_pkg.sv
// types and coefficient table for the voice-band FIR
// the table must stay FIR_TAPS long and sum to 2**FIR_SHIFT
`include "audio_defs.svh"

package audio_pkg;

  // one signed audio sample
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // one received I2S frame
  typedef struct packed {
    sample_t left;
    sample_t right;
  } frame_t;

  // full-width product of one tap
  typedef logic signed [`PROD_W-1:0] prod_t;

  // sample history, element 0 is the newest
  typedef sample_t [`FIR_TAPS-1:0] tap_vec_t;

  // low-pass, cutoff around the top of the voice band
  // symmetric, so tap order does not matter
  localparam sample_t FIR_COEF [`FIR_TAPS] = '{
    16'sd8,
    16'sd20,
    16'sd40,
    16'sd60,
    16'sd60,
    16'sd40,
    16'sd20,
    16'sd8
  };

endpackage

// File: hdl/fir_delay_line.sv
// history of left samples for the FIR, element 0 is the newest
// shifts once per received frame
`timescale 1ns/1ps
`include "audio_defs.svh"

module fir_delay_line import audio_pkg::*; (
  input  logic     sys_clk,
  input  logic     rst_n,
  input  logic     frame_vld,
  input  sample_t  left,
  output tap_vec_t taps,
  output logic     shift_vld
);

  // history starts from silence
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      taps <= '0;
    end else if (frame_vld) begin
      taps <= {taps[`FIR_TAPS-2:0], left};
    end
  end

  // taps are stable from this strobe on
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      shift_vld <= 1'b0;
    end else begin
      shift_vld <= frame_vld;
    end
  end

endmodule

// File: hdl/fir_sum.sv
// adds the tap products, scales by FIR_SHIFT and clamps to 16 bits
// bypass selects the raw newest sample, sampled on the output cycle
`timescale 1ns/1ps
`include "audio_defs.svh"

module fir_sum import audio_pkg::*; (
  input  logic                    sys_clk,
  input  logic                    rst_n,
  input  logic                    prod_vld,
  input  prod_t [`FIR_TAPS-1:0]   prods,
  input  sample_t                 raw,
  input  logic                    bypass,
  output sample_t                 out_sample,
  output logic                    out_vld
);

  // headroom for the sum of all taps
  localparam int ACC_W = `PROD_W + $clog2(`FIR_TAPS);

  logic signed [ACC_W-1:0] acc;
  logic signed [ACC_W-1:0] scaled;
  sample_t                 sat;
  sample_t                 raw_q;

  // raw lags the taps by one cycle, same as the products
  always_ff @(posedge sys_clk) begin
    raw_q <= raw;
  end

  always_comb begin
    acc = '0;
    for (int i = 0; i < `FIR_TAPS; i++) begin
      acc = acc + $signed(prods[i]);
    end
  end

  assign scaled = acc >>> `FIR_SHIFT;

  // upper bits all equal to the sign means it fits
  always_comb begin
    if (scaled[ACC_W-1:`SAMPLE_W-1] == '0 || scaled[ACC_W-1:`SAMPLE_W-1] == '1) begin
      sat = scaled[`SAMPLE_W-1:0];
    end else if (scaled[ACC_W-1]) begin
      sat = {1'b1, {(`SAMPLE_W-1){1'b0}}};
    end else begin
      sat = {1'b0, {(`SAMPLE_W-1){1'b1}}};
    end
  end

  always_ff @(posedge sys_clk) begin
    if (prod_vld) begin
      out_sample <= bypass ? raw_q : sat;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= prod_vld;
    end
  end

  a_out_lat: assert property (@(posedge sys_clk) disable iff (!rst_n)
    out_vld == $past(prod_vld));

endmodule

// File: hdl/fir_tap.sv
// one FIR tap, registered signed product of sample and coefficient
`timescale 1ns/1ps

module fir_tap import audio_pkg::*; #(
  parameter sample_t coef = 16'sd0
) (
  input  logic    sys_clk,
  input  logic    rst_n,
  input  logic    in_vld,
  input  sample_t x,
  output prod_t   prod,
  output logic    prod_vld
);

  // full 32-bit product, no rounding here
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      prod <= '0;
    end else if (in_vld) begin
      prod <= x * coef;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      prod_vld <= 1'b0;
    end else begin
      prod_vld <= in_vld;
    end
  end

endmodule

// File: hdl/i2s_rx.sv
// I2S slave receiver, standard format, 16 bclk per slot, MSB first
// bclk must run well below sys_clk/4 so every edge is seen after sync
`timescale 1ns/1ps
`include "audio_defs.svh"

module i2s_rx import audio_pkg::*; (
  input  logic   sys_clk,
  input  logic   rst_n,
  input  logic   bclk,
  input  logic   lrck,
  input  logic   sdin,
  output frame_t frame,
  output logic   frame_vld
);

  logic [2:0]           bclk_sync;
  logic [2:0]           lrck_sync;
  logic [1:0]           sdin_sync;
  logic                 bclk_rise;
  logic                 lrck_edge;
  logic                 word_done;
  logic                 left_ok;
  logic [3:0]           bit_cnt;
  logic [`SAMPLE_W-1:0] shreg;
  logic [`SAMPLE_W-1:0] word;

  // two flops against metastability, third one for edge detect
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      bclk_sync <= '0;
      lrck_sync <= '0;
    end else begin
      bclk_sync <= {bclk_sync[1:0], bclk};
      lrck_sync <= {lrck_sync[1:0], lrck};
    end
  end

  // data delayed the same as bclk
  always_ff @(posedge sys_clk) begin
    sdin_sync <= {sdin_sync[0], sdin};
  end

  assign bclk_rise = bclk_sync[1] & ~bclk_sync[2];
  assign lrck_edge = lrck_sync[1] ^ lrck_sync[2];
  assign word      = {shreg[`SAMPLE_W-2:0], sdin_sync[1]};

  // first rise of a slot carries the LSB of the slot before
  assign word_done = bclk_rise && (bit_cnt == 4'd0);

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (lrck_edge) begin
      bit_cnt <= '0;
    end else if (bclk_rise) begin
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (bclk_rise) begin
      shreg <= word;
    end
  end

  // lrck high now means the finished word was the left one
  always_ff @(posedge sys_clk) begin
    if (word_done) begin
      if (lrck_sync[1]) begin
        frame.left <= word;
      end else begin
        frame.right <= word;
      end
    end
  end

  // no strobe until a left word has been seen
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      left_ok   <= 1'b0;
      frame_vld <= 1'b0;
    end else begin
      if (word_done && lrck_sync[1]) begin
        left_ok <= 1'b1;
      end
      frame_vld <= word_done && !lrck_sync[1] && left_ok;
    end
  end

  a_vld_single: assert property (@(posedge sys_clk) disable iff (!rst_n)
    frame_vld |=> !frame_vld);

endmodule

// File: hdl/i2s_tx.sv
// I2S slave transmitter, same word in left and right slot, 16 bclk per slot
// assumes lrck changes on a bclk falling edge, both see the same sync delay
`timescale 1ns/1ps
`include "audio_defs.svh"

module i2s_tx import audio_pkg::*; (
  input  logic    sys_clk,
  input  logic    rst_n,
  input  logic    bclk,
  input  logic    lrck,
  input  logic    out_vld,
  input  sample_t out_sample,
  output logic    sdout
);

  logic [2:0]           bclk_sync;
  logic [2:0]           lrck_sync;
  logic                 bclk_fall;
  logic                 lrck_edge;
  logic                 lrck_fall;
  logic                 pending;
  sample_t              held;
  sample_t              cur;
  logic [`SAMPLE_W-1:0] shreg;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      bclk_sync <= '0;
      lrck_sync <= '0;
    end else begin
      bclk_sync <= {bclk_sync[1:0], bclk};
      lrck_sync <= {lrck_sync[1:0], lrck};
    end
  end

  assign bclk_fall = ~bclk_sync[1] & bclk_sync[2];
  assign lrck_edge = lrck_sync[1] ^ lrck_sync[2];
  assign lrck_fall = ~lrck_sync[1] & lrck_sync[2];

  // newest result waits here for the next frame start
  always_ff @(posedge sys_clk) begin
    if (out_vld) begin
      held <= out_sample;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
      cur     <= '0;
    end else if (lrck_fall && pending) begin
      pending <= out_vld;
      cur     <= held;
    end else if (out_vld) begin
      pending <= 1'b1;
    end
  end

  // slot edge loads, other falls shift
  // the fall at a slot edge still sends the LSB of the slot before
  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      shreg <= '0;
      sdout <= 1'b0;
    end else if (bclk_fall) begin
      sdout <= shreg[`SAMPLE_W-1];
      if (lrck_edge) begin
        shreg <= (lrck_fall && pending) ? held : cur;
      end else begin
        shreg <= {shreg[`SAMPLE_W-2:0], 1'b0};
      end
    end
  end

  a_sdout_rst: assert property (@(posedge sys_clk)
    !rst_n ##1 !rst_n |-> !sdout);

endmodule

// File: include/audio_defs.svh
// widths and sizes shared by the FIR datapath and the I2S blocks
// FIR_SHIFT must match the coefficient sum (2**8 = 256) for unity DC gain
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// audio word width on the I2S link
`define SAMPLE_W 16

// filter length
`define FIR_TAPS 8

// full product of sample and coefficient
`define PROD_W 32

// scaling after the sum
`define FIR_SHIFT 8

`endif

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_audio_fir -Mdir obj_dir -o tb_audio_fir \
  && {
    out=$(./obj_dir/tb_audio_fir)
    printf '%s\n' "$out"
    printf '%s\n' "$out" | grep -qx "All tests passed!"
  } \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+include
hdl/audio_pkg.sv
hdl/i2s_rx.sv
hdl/fir_delay_line.sv
hdl/fir_tap.sv
hdl/fir_sum.sv
hdl/i2s_tx.sv
hdl/audio_fir.sv
sim/tb_clock.sv
sim/tb_audio_fir.sv

// File: sim/tb_audio_fir.sv
// I2S master on the ADC side and a decoder on the DAC side
// input frame k comes back in the output frame that starts two lrck falls later
// bypass changes mid-frame, so each input frame has exactly one mode
`timescale 1ns/1ps
`include "audio_defs.svh"

module tb_audio_fir import audio_pkg::*; ();

  localparam int slot_bits    = `SAMPLE_W;
  localparam int lead_frames  = 3;
  localparam int max_frames   = 200;
  localparam int total_frames = 125;
  localparam int frame_ns     = 2600;

  logic    sys_clk;
  logic    rst_n;
  logic    bclk;
  logic    lrck;
  logic    sdin;
  logic    bypass;
  logic    sdout;

  integer  seed;
  logic    last_bit;
  int      n_sent;
  int      n_test;
  sample_t hist [`FIR_TAPS];
  sample_t exp_word [max_frames];

  logic                 bclk_q;
  logic                 lrck_q;
  logic [slot_bits-1:0] rx_shreg;
  logic [slot_bits-1:0] rx_word;
  sample_t              rx_left;
  int                   out_cnt;
  int                   chk_cnt;
  logic                 dec_vld;
  int                   dec_idx;
  sample_t              dec_left;
  sample_t              dec_right;
  sample_t              dec_exp;

  tb_clock #(.half_ns(5), .rst_cycles(3)) u_clk (
    .clk   (sys_clk),
    .rst_n (rst_n)
  );

  audio_fir u_dut (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .bclk    (bclk),
    .lrck    (lrck),
    .sdin    (sdin),
    .bypass  (bypass),
    .sdout   (sdout)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  function automatic sample_t rand_sample();
    int r;
    r = $random(seed);
    return r[slot_bits-1:0];
  endfunction

  function automatic logic rand_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // reference filter with history, coefficient sum, arithmetic shift and clamp
  task automatic model_step(input sample_t x, input logic byp, output sample_t y);
    int acc;
    int scaled;
    for (int i = `FIR_TAPS - 1; i > 0; i--) begin
      hist[i] = hist[i-1];
    end
    hist[0] = x;
    acc = 0;
    for (int i = 0; i < `FIR_TAPS; i++) begin
      acc = acc + int'(hist[i]) * int'(FIR_COEF[i]);
    end
    scaled = acc >>> `FIR_SHIFT;
    if (byp) begin
      y = x;
    end else if (scaled > 32767) begin
      y = 16'sh7fff;
    end else if (scaled < -32768) begin
      y = 16'sh8000;
    end else begin
      y = scaled[slot_bits-1:0];
    end
  endtask

  // one 80 ns bclk period with all changes on falling sys_clk edges
  task automatic bclk_cycle(input logic lr, input logic bit_v);
    @(negedge sys_clk);
    bclk = 1'b0;
    lrck = lr;
    sdin = bit_v;
    repeat (4) @(negedge sys_clk);
    bclk = 1'b1;
    repeat (3) @(negedge sys_clk);
  endtask

  // first bclk of each slot still carries the LSB of the slot before
  task automatic send_frame(input sample_t left, input sample_t right, input logic byp);
    sample_t y;
    logic    b;
    model_step(left, byp, y);
    exp_word[n_sent] = y;
    n_sent = n_sent + 1;
    for (int j = 0; j < 2 * slot_bits; j++) begin
      if (j == 0) begin
        b = last_bit;
      end else if (j <= slot_bits) begin
        b = left[slot_bits-j];
      end else begin
        b = right[2*slot_bits-j];
      end
      if (j == 8) begin
        bypass = byp;
      end
      bclk_cycle(j >= slot_bits, b);
    end
    last_bit = right[0];
  endtask

  assign rx_word = {rx_shreg[slot_bits-2:0], sdout};

  // DAC side decoder where a slot ends on the first bclk rise after lrck moves
  always @(posedge sys_clk) begin
    if (!rst_n) begin
      bclk_q    <= 1'b0;
      lrck_q    <= 1'b1;
      rx_shreg  <= '0;
      rx_left   <= '0;
      out_cnt   <= 0;
      chk_cnt   <= 0;
      dec_vld   <= 1'b0;
      dec_idx   <= 0;
      dec_left  <= '0;
      dec_right <= '0;
      dec_exp   <= '0;
    end else begin
      bclk_q  <= bclk;
      dec_vld <= 1'b0;
      if (bclk && !bclk_q) begin
        rx_shreg <= rx_word;
        if (lrck != lrck_q) begin
          lrck_q <= lrck;
          if (lrck) begin
            rx_left <= rx_word;
          end else begin
            dec_vld   <= 1'b1;
            dec_idx   <= out_cnt - lead_frames;
            dec_left  <= rx_left;
            dec_right <= rx_word;
            dec_exp   <= (out_cnt >= lead_frames) ? exp_word[out_cnt-lead_frames] : '0;
            out_cnt   <= out_cnt + 1;
            if (out_cnt >= lead_frames) begin
              chk_cnt <= chk_cnt + 1;
            end
          end
        end
      end
    end
  end

  // nothing on the DAC link before the first filtered word
  a_quiet: assert property (@(posedge sys_clk) disable iff (!rst_n)
    (out_cnt < lead_frames) |-> !sdout)
    else abort_run($sformatf("CHECK FAILED at %0t ns: sdout got %b expected %b",
                             $time, $sampled(sdout), 1'b0));

  a_left: assert property (@(posedge sys_clk) disable iff (!rst_n)
    dec_vld |-> (dec_left == dec_exp))
    else abort_run($sformatf(
      "CHECK FAILED at %0t ns: sdout left slot, frame %0d, got %h expected %h",
      $time, dec_idx, dec_left, dec_exp));

  a_right: assert property (@(posedge sys_clk) disable iff (!rst_n)
    dec_vld |-> (dec_right == dec_exp))
    else abort_run($sformatf(
      "CHECK FAILED at %0t ns: sdout right slot, frame %0d, got %h expected %h",
      $time, dec_idx, dec_right, dec_exp));

  initial begin
    bclk     = 1'b0;
    lrck     = 1'b1;
    sdin     = 1'b0;
    bypass   = 1'b0;
    seed     = 32'h82e21cb3;
    last_bit = 1'b0;
    n_sent   = 0;
    for (int i = 0; i < `FIR_TAPS; i++) begin
      hist[i] = '0;
    end
    wait (rst_n === 1'b1);
    repeat (4) @(negedge sys_clk);
    // lone nonzero frame that the output must not show early
    send_frame(16'sd4096, rand_sample(), 1'b0);
    // silence clears the history before the impulse
    repeat (7) send_frame('0, rand_sample(), 1'b0);
    // impulse of 256 reads out the coefficients
    send_frame(16'sd256, rand_sample(), 1'b0);
    repeat (9) send_frame('0, rand_sample(), 1'b0);
    // steps settle at the input value
    repeat (12) send_frame(16'sd1000, rand_sample(), 1'b0);
    repeat (12) send_frame(-16'sd3000, rand_sample(), 1'b0);
    // full scale alternating then held
    for (int i = 0; i < 8; i++) begin
      send_frame(i[0] ? 16'sh8000 : 16'sh7fff, rand_sample(), 1'b0);
    end
    repeat (10) send_frame(16'sh8000, rand_sample(), 1'b0);
    repeat (10) send_frame(16'sh7fff, rand_sample(), 1'b0);
    // raw path with the right input still random
    repeat (12) send_frame(rand_sample(), rand_sample(), 1'b1);
    repeat (40) send_frame(rand_sample(), rand_sample(), rand_bit());
    n_test = n_sent;
    // two more frames and one bit push the last results out
    send_frame('0, '0, 1'b0);
    send_frame('0, '0, 1'b0);
    bclk_cycle(1'b0, last_bit);
    wait (chk_cnt == n_test);
    repeat (4) @(posedge sys_clk);
    $display("All tests passed!");
    $finish;
  end

  // about 2.6 us per frame on the link
  initial begin
    #(total_frames * frame_ns + 20000);
    abort_run("timeout: the simulation hung before all output frames were checked");
  end

endmodule

// File: sim/tb_clock.sv
// testbench clock and reset source
// reset is released on a falling edge, like every other driven input
`timescale 1ns/1ps

module tb_clock #(
  parameter int half_ns    = 5,
  parameter int rst_cycles = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #half_ns clk = ~clk;
  end

  // low for rst_cycles rising edges
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule
